/* Bender.yml */
package:
  name: rob

sources:
  - files:
      - rob_pkg.sv
      - rob_pointers.sv
      - rob_entry_store.sv
      - rob_commit_select.sv
      - rob_ctrl_regs.sv
      - rob_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - rob_tb.sv

/* project.f */
rob_pkg.sv
rob_pointers.sv
rob_entry_store.sv
rob_commit_select.sv
rob_ctrl_regs.sv
rob_top.sv
tb_clock_gen.sv
rob_tb.sv

/* rob_commit_select.sv */
`default_nettype none

module rob_commit_select
    import rob_pkg::*;
(
    input  uop_t    head_uop0,
    input  uop_t    head_uop1,
    input  logic    empty,
    input  logic    commit_ready,
    output commit_t commit,
    output logic    commit_valid,
    output logic    commit0,
    output logic    commit1,
    output logic    advance
);

    logic ready0;
    logic ready1;
    logic good0;
    logic good1;
    logic done0;
    logic done1;
    logic fire;

    // finished and still waiting to retire
    assign ready0 = head_uop0.valid && !head_uop0.committed && !head_uop0.busy;
    assign ready1 = head_uop1.valid && !head_uop1.committed && !head_uop1.busy;

    assign good0 = ready0 && !empty;

    // slot 1 waits for slot 0: already gone, or going in this same handshake
    assign good1 = ready1 && !empty
                   && (!head_uop0.valid || head_uop0.committed || good0);

    assign commit_valid = good0 || good1;
    assign fire         = commit_valid && commit_ready;

    assign commit0 = fire && good0;
    assign commit1 = fire && good1;

    // invalid slot counts as done
    assign done0 = !head_uop0.valid || head_uop0.committed || commit0;
    assign done1 = !head_uop1.valid || head_uop1.committed || commit1;

    assign advance = done0 && done1 && !empty;

    assign commit.uop0  = head_uop0;
    assign commit.uop1  = head_uop1;
    assign commit.good0 = good0;
    assign commit.good1 = good1;

endmodule

`default_nettype wire

/* rob_ctrl_regs.sv */
`default_nettype none

module rob_ctrl_regs
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  cfg_we,
    input  logic [cfg_addr_w-1:0] cfg_addr,
    input  logic [data_w-1:0]     cfg_wdata,
    output logic [data_w-1:0]     cfg_rdata,
    input  logic                  commit0,
    input  logic                  commit1,
    input  logic [occ_w-1:0]      occupancy,
    input  logic                  full,
    output logic                  flush_pulse
);

    logic              flush_q;
    logic [1:0]        inc_q;
    logic [data_w-1:0] count_q;
    status_t           status;

    // self clearing, high only on the cycle after the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= cfg_we && (cfg_addr == reg_addr_ctrl) && cfg_wdata[0];
        end
    end

    assign flush_pulse = flush_q;

    // commit strobes registered first, count follows one edge later
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            inc_q   <= '0;
            count_q <= '0;
        end else begin
            inc_q   <= 2'(commit0) + 2'(commit1);
            count_q <= count_q + data_w'(inc_q);
        end
    end

    assign status.rsvd      = '0;
    assign status.full      = full;
    assign status.occupancy = occupancy;

    // readback
    always_comb begin
        case (cfg_addr)
            reg_addr_ctrl:   cfg_rdata = {{(data_w-1){1'b0}}, flush_q};
            reg_addr_status: cfg_rdata = status;
            reg_addr_count:  cfg_rdata = count_q;
            default:         cfg_rdata = '0;
        endcase
    end

    // flush command lasts exactly one cycle
    a_flush_single : assert property (
        @(posedge clk) disable iff (!arst_n)
        flush_pulse |=> !flush_pulse
    ) else $error("rob_ctrl_regs: flush_pulse held for two cycles");

endmodule

`default_nettype wire

/* rob_entry_store.sv */
`default_nettype none

module rob_entry_store
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  push,
    input  logic [rob_addr_w-1:0] tail,
    input  dispatch_t             disp,
    input  complete_t             cpl_alu0,
    input  complete_t             cpl_alu1,
    input  complete_t             cpl_mdu,
    input  complete_t             cpl_lsu,
    input  logic [rob_addr_w-1:0] head,
    input  logic                  commit0,
    input  logic                  commit1,
    output uop_t                  head_uop0,
    output uop_t                  head_uop1
);

    // slot 0 holds the older micro-op of each entry
    uop_t slot0_q [rob_size];
    uop_t slot1_q [rob_size];

    // completion ports in priority order, alus first
    complete_t cpl_all [num_cpl];

    assign cpl_all[0] = cpl_alu0;
    assign cpl_all[1] = cpl_alu1;
    assign cpl_all[2] = cpl_mdu;
    assign cpl_all[3] = cpl_lsu;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < rob_size; i++) begin
                slot0_q[i] <= '0;
                slot1_q[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < rob_size; i++) begin
                slot0_q[i] <= '0;
                slot1_q[i] <= '0;
            end
        end else begin
            // dispatch write at tail, id stamped here
            if (push) begin
                slot0_q[tail]           <= disp.uop0;
                slot0_q[tail].id        <= {tail, 1'b0};
                slot0_q[tail].committed <= 1'b0;

                slot1_q[tail]           <= disp.uop1;
                slot1_q[tail].id        <= {tail, 1'b1};
                slot1_q[tail].committed <= 1'b0;
            end

            // writeback, only alu ports update the branch outcome
            for (int p = 0; p < num_cpl; p++) begin
                if (cpl_all[p].set_finish) begin
                    if (cpl_all[p].id[0]) begin
                        slot1_q[cpl_all[p].id[uop_id_w-1:1]].busy <= 1'b0;
                        if (p < num_alu && cpl_all[p].set_branch) begin
                            slot1_q[cpl_all[p].id[uop_id_w-1:1]].branch_taken <=
                                cpl_all[p].branch_taken;
                            slot1_q[cpl_all[p].id[uop_id_w-1:1]].branch_addr <=
                                cpl_all[p].branch_addr;
                        end
                    end else begin
                        slot0_q[cpl_all[p].id[uop_id_w-1:1]].busy <= 1'b0;
                        if (p < num_alu && cpl_all[p].set_branch) begin
                            slot0_q[cpl_all[p].id[uop_id_w-1:1]].branch_taken <=
                                cpl_all[p].branch_taken;
                            slot0_q[cpl_all[p].id[uop_id_w-1:1]].branch_addr <=
                                cpl_all[p].branch_addr;
                        end
                    end
                end
            end

            // committed marking at head
            if (commit0) begin
                slot0_q[head].committed <= 1'b1;
            end
            if (commit1) begin
                slot1_q[head].committed <= 1'b1;
            end
        end
    end

    assign head_uop0 = slot0_q[head];
    assign head_uop1 = slot1_q[head];

    // a unit may only report micro-ops that were dispatched earlier
    for (genvar p = 0; p < num_cpl; p++) begin : g_cpl_chk
        a_cpl_target_valid : assert property (
            @(posedge clk) disable iff (!arst_n)
            cpl_all[p].set_finish |->
                (cpl_all[p].id[0] ? slot1_q[cpl_all[p].id[uop_id_w-1:1]].valid
                                  : slot0_q[cpl_all[p].id[uop_id_w-1:1]].valid)
        ) else $error("rob_entry_store: completion to invalid slot on port %0d", p);
    end

endmodule

`default_nettype wire

/* rob_input.txt */
// op a b c d e in hex. 1 dispatch pc0 opc0opc1 tail baddr. 2 complete port id setb taken addr
// 3 commit goods entry takens addr0 addr1. 4 stall n valid. 5 flush valid ready. 6 read addr val
7 1 0 0 0 0
6 1 0 0 0 0
1 1000 1122 0 c0 0
1 1010 3344 1 0 0
1 1020 5566 2 0 0
1 1030 7788 3 0 0
1 1040 99aa 4 0 0
1 1050 bbcc 5 0 0
1 1060 ddee 6 0 0
7 0 0 0 0 0
6 1 17 0 0 0
2 1 1 1 1 4000
4 2 0 0 0 0
2 2 0 1 1 dead
3 3 0 1 c0 4000
4 2 0 0 0 0
6 2 2 0 0 0
7 1 0 0 0 0
2 3 7 0 0 0
2 0 6 1 0 5000
2 2 2 0 0 0
3 2 1 0 0 0
2 1 3 1 1 6000
3 1 1 1 0 6000
2 1 4 1 1 7000
2 3 5 0 0 0
3 3 2 2 7000 0
3 3 3 0 5000 0
2 0 8 0 0 0
4 3 1 0 0 0
3 2 4 0 0 0
4 2 0 0 0 0
6 2 9 0 0 0
2 2 9 0 0 0
3 1 4 0 0 0
4 2 0 0 0 0
6 2 a 0 0 0
6 1 2 0 0 0
2 3 a 0 0 0
7 1 1 0 0 0
5 0 1 0 0 0
6 1 0 0 0 0
6 2 a 0 0 0
1 2000 f0f1 0 0 0
2 0 1 1 1 8000
2 1 0 0 0 0
3 3 0 1 0 8000
4 2 0 0 0 0
6 2 c 0 0 0
7 1 0 0 0 0
0 0 0 0 0 0

/* rob_pkg.sv */
`default_nettype none

package rob_pkg;

    // buffer geometry
    localparam int rob_size   = 8;
    localparam int rob_addr_w = 3;
    localparam int occ_w      = rob_addr_w + 1;

    // id is the entry index followed by the slot bit
    localparam int uop_id_w = rob_addr_w + 1;

    // pc and branch target width
    localparam int data_w = 32;

    // completion sources, the first num_alu ports carry branch outcomes
    localparam int num_cpl = 4;
    localparam int num_alu = 2;

    // register block
    localparam int cfg_addr_w = 2;
    localparam logic [cfg_addr_w-1:0] reg_addr_ctrl   = 2'd0;
    localparam logic [cfg_addr_w-1:0] reg_addr_status = 2'd1;
    localparam logic [cfg_addr_w-1:0] reg_addr_count  = 2'd2;

    // one micro-op slot
    typedef struct packed {
        logic                valid;
        logic                busy;
        logic                committed;
        logic [uop_id_w-1:0] id;
        logic [data_w-1:0]   pc;
        logic [7:0]          opcode;
        logic                branch_taken;
        logic [data_w-1:0]   branch_addr;
    } uop_t;

    // a dispatch group, uop0 is the older one
    typedef struct packed {
        uop_t uop0;
        uop_t uop1;
    } dispatch_t;

    // completion report from one functional unit
    typedef struct packed {
        logic                set_finish;
        logic [uop_id_w-1:0] id;
        logic                set_branch;
        logic                branch_taken;
        logic [data_w-1:0]   branch_addr;
    } complete_t;

    // head entry as seen by the commit stage
    typedef struct packed {
        uop_t uop0;
        uop_t uop1;
        logic good0;
        logic good1;
    } commit_t;

    // status register layout
    typedef struct packed {
        logic [data_w-occ_w-2:0] rsvd;
        logic                    full;
        logic [occ_w-1:0]        occupancy;
    } status_t;

endpackage

`default_nettype wire

/* rob_pointers.sv */
`default_nettype none

module rob_pointers
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  flush,
    input  logic                  push,
    input  logic                  advance,
    output logic [rob_addr_w-1:0] head,
    output logic [rob_addr_w-1:0] tail,
    output logic                  full,
    output logic                  empty,
    output logic [occ_w-1:0]      occupancy
);

    // msb of each pointer is the wrap bit
    logic [rob_addr_w:0] head_q;
    logic [rob_addr_w:0] tail_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_q <= '0;
        end else if (flush) begin
            tail_q <= '0;
        end else if (push) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q <= '0;
        end else if (flush) begin
            head_q <= '0;
        end else if (advance) begin
            head_q <= head_q + 1'b1;
        end
    end

    assign head = head_q[rob_addr_w-1:0];
    assign tail = tail_q[rob_addr_w-1:0];

    // difference of wrapped pointers gives the entry count directly
    assign occupancy = tail_q - head_q;
    assign empty     = (head_q == tail_q);

    // one entry is always left open
    assign full = (occupancy >= occ_w'(rob_size - 1));

    // dispatch handshake upstream must respect full
    a_no_push_when_full : assert property (
        @(posedge clk) disable iff (!arst_n)
        push |-> !full
    ) else $error("rob_pointers: push while full");

endmodule

`default_nettype wire

/* rob_tb.sv */
`default_nettype none

module rob_tb
    import rob_pkg::*;
();

    logic                  clk;
    logic                  arst_n;
    logic                  disp_valid;
    dispatch_t             disp;
    logic                  disp_ready;
    logic [rob_addr_w-1:0] disp_id;
    complete_t             cpl [num_cpl];
    commit_t               commit;
    logic                  commit_valid;
    logic                  commit_ready;
    logic                  cfg_we;
    logic [cfg_addr_w-1:0] cfg_addr;
    logic [data_w-1:0]     cfg_wdata;
    logic [data_w-1:0]     cfg_rdata;

    // six hex words per operation
    logic [31:0] stim [0:383];
    logic [31:0] exp_pc [2*rob_size];
    logic [7:0]  exp_opc [2*rob_size];
    int unsigned wait_limit = 64;
    int          errors;
    int          op_errors;
    bit          timed_out;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rob_top u_rob_top (
        .clk          (clk),
        .arst_n       (arst_n),
        .disp_valid   (disp_valid),
        .disp         (disp),
        .disp_ready   (disp_ready),
        .disp_id      (disp_id),
        .cpl_alu0     (cpl[0]),
        .cpl_alu1     (cpl[1]),
        .cpl_mdu      (cpl[2]),
        .cpl_lsu      (cpl[3]),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit_ready (commit_ready),
        .cfg_we       (cfg_we),
        .cfg_addr     (cfg_addr),
        .cfg_wdata    (cfg_wdata),
        .cfg_rdata    (cfg_rdata)
    );

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic compare(input string what, input logic [191:0] got,
                           input logic [191:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", what, got, exp);
            errors++;
            op_errors++;
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        timed_out = 1'b1;
        errors++;
        op_errors++;
    endtask

    task automatic dispatch_group(input logic [31:0] pc0, input logic [31:0] opcs,
                                  input logic [31:0] exp_tail, input logic [31:0] baddr);
        dispatch_t           d;
        logic [uop_id_w-1:0] id0;
        int                  n;
        id0 = {exp_tail[rob_addr_w-1:0], 1'b0};
        d = '0;
        // the store stamps its own id and clears committed
        d.uop0.valid       = 1'b1;
        d.uop0.busy        = 1'b1;
        d.uop0.committed   = 1'b1;
        d.uop0.id          = '1;
        d.uop0.pc          = pc0;
        d.uop0.opcode      = opcs[15:8];
        d.uop0.branch_addr = baddr;
        d.uop1             = d.uop0;
        d.uop1.pc          = pc0 + 32'd4;
        d.uop1.opcode      = opcs[7:0];
        exp_pc[id0]       = pc0;
        exp_pc[id0 + 1]   = pc0 + 32'd4;
        exp_opc[id0]      = opcs[15:8];
        exp_opc[id0 + 1]  = opcs[7:0];
        disp       = d;
        disp_valid = 1'b1;
        n = 0;
        while (!disp_ready && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!disp_ready) begin
            give_up("disp_ready");
        end else begin
            compare("disp_id", disp_id, exp_tail);
        end
        next_cycle();
        disp_valid = 1'b0;
    endtask

    task automatic send_completion(input logic [31:0] port, input logic [31:0] id,
                                   input logic [31:0] set_branch, input logic [31:0] taken,
                                   input logic [31:0] baddr);
        complete_t c;
        c.set_finish   = 1'b1;
        c.id           = id[uop_id_w-1:0];
        c.set_branch   = set_branch[0];
        c.branch_taken = taken[0];
        c.branch_addr  = baddr;
        cpl[port[1:0]] = c;
        next_cycle();
        cpl[port[1:0]] = '0;
    endtask

    task automatic check_slot(input string slot, input uop_t u,
                              input logic [uop_id_w-1:0] id, input logic taken,
                              input logic [31:0] baddr);
        compare({slot, ".id"}, u.id, id);
        compare({slot, ".pc"}, u.pc, exp_pc[id]);
        compare({slot, ".opcode"}, u.opcode, exp_opc[id]);
        compare({slot, ".branch_taken"}, u.branch_taken, taken);
        compare({slot, ".branch_addr"}, u.branch_addr, baddr);
    endtask

    // goods bit 1 is slot 0, takens uses the same order
    task automatic retire_head(input logic [31:0] goods, input logic [31:0] entry,
                               input logic [31:0] takens, input logic [31:0] baddr0,
                               input logic [31:0] baddr1);
        int n;
        n = 0;
        while (!commit_valid && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (!commit_valid) begin
            give_up("commit_valid");
        end else begin
            compare("commit.good0", commit.good0, goods[1]);
            compare("commit.good1", commit.good1, goods[0]);
            if (goods[1]) begin
                check_slot("commit.uop0", commit.uop0, {entry[rob_addr_w-1:0], 1'b0},
                           takens[1], baddr0);
            end
            if (goods[0]) begin
                check_slot("commit.uop1", commit.uop1, {entry[rob_addr_w-1:0], 1'b1},
                           takens[0], baddr1);
            end
            commit_ready = 1'b1;
            next_cycle();
            commit_ready = 1'b0;
        end
    endtask

    task automatic hold_commit(input logic [31:0] cycles, input logic [31:0] exp_valid);
        commit_t snap;
        snap = commit;
        commit_ready = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            next_cycle();
            compare("commit_valid", commit_valid, exp_valid[0]);
            compare("commit", commit, snap);
        end
    endtask

    task automatic flush_buffer(input logic [31:0] exp_valid, input logic [31:0] exp_ready);
        cfg_we    = 1'b1;
        cfg_addr  = reg_addr_ctrl;
        cfg_wdata = 32'h1;
        next_cycle();
        cfg_we    = 1'b0;
        cfg_wdata = '0;
        #1;
        // pulse visible in the control register for one cycle
        compare("cfg_rdata", cfg_rdata, 32'h1);
        next_cycle();
        compare("commit_valid", commit_valid, exp_valid[0]);
        compare("disp_ready", disp_ready, exp_ready[0]);
    endtask

    task automatic read_register(input logic [31:0] addr, input logic [31:0] exp);
        cfg_addr = addr[cfg_addr_w-1:0];
        #1;
        compare("cfg_rdata", cfg_rdata, exp);
        next_cycle();
    endtask

    task automatic check_handshake(input logic [31:0] exp_ready, input logic [31:0] exp_valid);
        compare("disp_ready", disp_ready, exp_ready[0]);
        compare("commit_valid", commit_valid, exp_valid[0]);
    endtask

    initial begin
        int          n;
        int          base;
        int          ops_run;
        logic [31:0] op;
        string       name;
        disp_valid   = 1'b0;
        disp         = '0;
        commit_ready = 1'b0;
        cfg_we       = 1'b0;
        cfg_addr     = '0;
        cfg_wdata    = '0;
        for (int p = 0; p < num_cpl; p++) begin
            cpl[p] = '0;
        end
        errors    = 0;
        timed_out = 1'b0;
        ops_run   = 0;
        $readmemh("rob_input.txt", stim);

        n = 0;
        while (arst_n !== 1'b1 && n < 100) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            give_up("reset release");
        end
        next_cycle();

        for (int i = 0; i < 64; i++) begin
            if (timed_out) begin
                break;
            end
            base = i * 6;
            op   = stim[base];
            if ($isunknown(op) || op == 0) begin
                break;
            end
            op_errors = 0;
            case (op)
                1: begin
                    name = "dispatch";
                    dispatch_group(stim[base+1], stim[base+2], stim[base+3], stim[base+4]);
                end
                2: begin
                    name = "complete";
                    send_completion(stim[base+1], stim[base+2], stim[base+3],
                                    stim[base+4], stim[base+5]);
                end
                3: begin
                    name = "commit";
                    retire_head(stim[base+1], stim[base+2], stim[base+3],
                                stim[base+4], stim[base+5]);
                end
                4: begin
                    name = "stall";
                    hold_commit(stim[base+1], stim[base+2]);
                end
                5: begin
                    name = "flush";
                    flush_buffer(stim[base+1], stim[base+2]);
                end
                6: begin
                    name = "read";
                    read_register(stim[base+1], stim[base+2]);
                end
                7: begin
                    name = "handshake";
                    check_handshake(stim[base+1], stim[base+2]);
                end
                default: begin
                    name = "unknown";
                    $display("unknown operation code %0h in the stimulus file", op);
                    errors++;
                    op_errors++;
                end
            endcase
            ops_run++;
            $display("op %0d %s finished with %0d errors", i, name, op_errors);
        end

        $display("operations run %0d, errors %0d", ops_run, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rob_top.sv */
`default_nettype none

module rob_top
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  arst_n,
    // dispatch
    input  logic                  disp_valid,
    input  dispatch_t             disp,
    output logic                  disp_ready,
    output logic [rob_addr_w-1:0] disp_id,
    // completion strobes
    input  complete_t             cpl_alu0,
    input  complete_t             cpl_alu1,
    input  complete_t             cpl_mdu,
    input  complete_t             cpl_lsu,
    // commit
    output commit_t               commit,
    output logic                  commit_valid,
    input  logic                  commit_ready,
    // register port
    input  logic                  cfg_we,
    input  logic [cfg_addr_w-1:0] cfg_addr,
    input  logic [data_w-1:0]     cfg_wdata,
    output logic [data_w-1:0]     cfg_rdata
);

    logic [rob_addr_w-1:0] head;
    logic [rob_addr_w-1:0] tail;
    logic                  full;
    logic                  empty;
    logic [occ_w-1:0]      occupancy;
    logic                  push;
    logic                  advance;
    logic                  commit0;
    logic                  commit1;
    logic                  flush_pulse;
    uop_t                  head_uop0;
    uop_t                  head_uop1;

    assign disp_ready = !full;
    assign push       = disp_valid && disp_ready;
    assign disp_id    = tail;

    rob_pointers u_pointers (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush_pulse),
        .push      (push),
        .advance   (advance),
        .head      (head),
        .tail      (tail),
        .full      (full),
        .empty     (empty),
        .occupancy (occupancy)
    );

    rob_entry_store u_entry_store (
        .clk       (clk),
        .arst_n    (arst_n),
        .flush     (flush_pulse),
        .push      (push),
        .tail      (tail),
        .disp      (disp),
        .cpl_alu0  (cpl_alu0),
        .cpl_alu1  (cpl_alu1),
        .cpl_mdu   (cpl_mdu),
        .cpl_lsu   (cpl_lsu),
        .head      (head),
        .commit0   (commit0),
        .commit1   (commit1),
        .head_uop0 (head_uop0),
        .head_uop1 (head_uop1)
    );

    rob_commit_select u_commit_select (
        .head_uop0    (head_uop0),
        .head_uop1    (head_uop1),
        .empty        (empty),
        .commit_ready (commit_ready),
        .commit       (commit),
        .commit_valid (commit_valid),
        .commit0      (commit0),
        .commit1      (commit1),
        .advance      (advance)
    );

    rob_ctrl_regs u_ctrl_regs (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .commit0     (commit0),
        .commit1     (commit1),
        .occupancy   (occupancy),
        .full        (full),
        .flush_pulse (flush_pulse)
    );

endmodule

`default_nettype wire

/* tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // period 4
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held for 16 cycles, released just after an edge
    initial begin
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule

`default_nettype wire
